// File: Makefile
# Verilator build and run for the pipelined core and its testbench

TOP        ?= cpu_tb
RTL_TOP    ?= cpu
FILELIST   ?= project.f
OBJDIR     ?= obj_dir
FLAGS      ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	verilator $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	verilator $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	verilator $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

// File: bench/cpu_tb.sv
/*
 * directed testbench for the pipelined core
 * instruction encoders, external memory access, program runs, result checks
 * tests: memory ports, ALU ops, forwarding, load-use, freeze and register 0
 */
`include "cpu_macros.svh"

module cpu_tb
   import isa_pkg::*;
();

   logic                    clk;
   logic                    rst_n;
   logic                    enable;
   logic [`CPU_IMEM_AW-1:0] addr_ext;
   logic                    wen_ext;
   logic                    ren_ext;
   word_t                   wdata_ext;
   word_t                   rdata_ext;
   logic [`CPU_DMEM_AW-1:0] addr_ext_2;
   logic                    wen_ext_2;
   logic                    ren_ext_2;
   word_t                   wdata_ext_2;
   word_t                   rdata_ext_2;

   integer seed;
   int     errors;
   int     checks;
   word_t  prog[$];
   // expected values of the result slots, data memory words 64 and up
   word_t  expect_q[$];

   cpu dut (.*);

   always #2 clk = ~clk;

   function automatic word_t r_word(funct_e funct, int rd, int rs, int rt);
      return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
   endfunction

   function automatic word_t i_word(opcode_e op, int rt, int rs, logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   // differing signs decide on their own, equal signs compare as unsigned
   function automatic word_t signed_less(word_t a, word_t b);
      if (a[`CPU_DATA_W-1] != b[`CPU_DATA_W-1]) begin
         return word_t'(a[`CPU_DATA_W-1]);
      end
      return word_t'(a < b);
   endfunction

   task automatic check(input word_t got, input word_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic emit(input word_t instr, input int gap);
      prog.push_back(instr);
      repeat (gap) prog.push_back('0);
   endtask

   // byte address 0x100 is data memory word 64
   task automatic store_result(input int rt, input word_t exp);
      prog.push_back(i_word(OP_SW, rt, 0, 16'h100 + 16'(4 * expect_q.size())));
      expect_q.push_back(exp);
   endtask

   task automatic write_imem(input int addr, input word_t data);
      addr_ext  = addr[`CPU_IMEM_AW-1:0];
      wdata_ext = data;
      wen_ext   = 1'b1;
      @(negedge clk);
      wen_ext   = 1'b0;
   endtask

   task automatic read_imem(input int addr, output word_t data);
      addr_ext = addr[`CPU_IMEM_AW-1:0];
      ren_ext  = 1'b1;
      @(negedge clk);
      ren_ext  = 1'b0;
      data     = rdata_ext;
   endtask

   task automatic load_dmem(input int addr, input word_t data);
      addr_ext_2  = addr[`CPU_DMEM_AW-1:0];
      wdata_ext_2 = data;
      wen_ext_2   = 1'b1;
      @(negedge clk);
      wen_ext_2   = 1'b0;
   endtask

   task automatic read_dmem(input int addr, output word_t data);
      addr_ext_2 = addr[`CPU_DMEM_AW-1:0];
      ren_ext_2  = 1'b1;
      @(negedge clk);
      ren_ext_2  = 1'b0;
      data       = rdata_ext_2;
   endtask

   task automatic load_imem();
      foreach (prog[i]) begin
         write_imem(i, prog[i]);
      end
   endtask

   task automatic reset_core();
      enable = 1'b0;
      rst_n  = 1'b0;
      repeat (10) @(negedge clk);
      rst_n  = 1'b1;
   endtask

   // runs until the last word of the program has been fetched
   task automatic run_program(input int freeze_at, input int freeze_len);
      int cycles;
      cycles = 0;
      while (dut.pc_q < word_t'(4 * prog.size())) begin
         if (cycles == 200) begin
            $display("timeout: program did not finish within 200 cycles");
            $display("SIMULATION FAILED");
            $finish;
         end
         enable = !(cycles >= freeze_at && cycles < freeze_at + freeze_len);
         @(negedge clk);
         cycles++;
      end
      enable = 1'b0;
   endtask

   task automatic execute(input string name, input int freeze_at, input int freeze_len);
      word_t got;
      // trailing nops drain the last store through MEM
      emit('0, 7);
      load_imem();
      foreach (expect_q[k]) begin
         load_dmem(64 + k, 32'hdead_0000 ^ word_t'(64 + k));
      end
      reset_core();
      run_program(freeze_at, freeze_len);
      foreach (expect_q[k]) begin
         read_dmem(64 + k, got);
         check(got, expect_q[k], $sformatf("%s result %0d", name, k));
      end
      prog.delete();
      expect_q.delete();
   endtask

   task automatic ext_port_readback();
      word_t iwords[8];
      word_t dwords[8];
      word_t got;
      for (int i = 0; i < 8; i++) begin
         iwords[i] = $random(seed);
         dwords[i] = $random(seed);
         write_imem(i * 61 + 3, iwords[i]);
         load_dmem(i * 127 + 5, dwords[i]);
      end
      for (int i = 0; i < 8; i++) begin
         read_imem(i * 61 + 3, got);
         check(got, iwords[i], $sformatf("imem word %0d", i * 61 + 3));
         read_dmem(i * 127 + 5, got);
         check(got, dwords[i], $sformatf("dmem word %0d", i * 127 + 5));
      end
   endtask

   task automatic alu_ops();
      word_t       a;
      word_t       b;
      logic [15:0] imm;
      a   = $random(seed);
      b   = $random(seed);
      imm = 16'($random(seed));
      load_dmem(0, a);
      load_dmem(1, b);
      emit(i_word(OP_LW, 1, 0, 16'h0), 0);
      emit(i_word(OP_LW, 2, 0, 16'h4), 3);
      emit(i_word(OP_ADDI, 3, 1, imm), 2);
      emit(r_word(F_ADD, 4, 1, 2), 2);
      emit(r_word(F_SUB, 5, 1, 2), 2);
      emit(r_word(F_AND, 6, 1, 2), 2);
      emit(r_word(F_OR, 7, 1, 2), 2);
      emit(r_word(F_SLT, 8, 1, 2), 2);
      emit(r_word(F_SLT, 9, 2, 1), 3);
      store_result(3, a + {{16{imm[15]}}, imm});
      store_result(4, a + b);
      store_result(5, a - b);
      store_result(6, a & b);
      store_result(7, a | b);
      store_result(8, signed_less(a, b));
      store_result(9, signed_less(b, a));
      execute("alu", 0, 0);
   endtask

   task automatic forwarding_paths();
      word_t r[11];
      r[1] = $random(seed);
      r[2] = $random(seed);
      load_dmem(0, r[1]);
      load_dmem(1, r[2]);
      emit(i_word(OP_LW, 1, 0, 16'h0), 0);
      emit(i_word(OP_LW, 2, 0, 16'h4), 3);
      emit(r_word(F_ADD, 3, 1, 2), 0);
      emit(r_word(F_SUB, 4, 3, 1), 0);
      emit(r_word(F_OR, 5, 2, 4), 0);
      // one instruction between producer and consumer
      emit(r_word(F_ADD, 6, 4, 2), 0);
      emit(r_word(F_SLT, 7, 1, 5), 0);
      emit(i_word(OP_ADDI, 8, 7, 16'd5), 0);
      emit(r_word(F_ADD, 8, 8, 8), 0);
      // r8 in both EX/MEM and MEM/WB, the newer one counts
      emit(r_word(F_ADD, 10, 8, 1), 0);
      r[3]  = r[1] + r[2];
      r[4]  = r[3] - r[1];
      r[5]  = r[2] | r[4];
      r[6]  = r[4] + r[2];
      r[7]  = signed_less(r[1], r[5]);
      r[8]  = (r[7] + 32'd5) + (r[7] + 32'd5);
      r[10] = r[8] + r[1];
      // store data forwarded straight from EX/MEM
      store_result(10, r[10]);
      emit('0, 2);
      for (int i = 3; i <= 8; i++) begin
         store_result(i, r[i]);
      end
      execute("forwarding", 0, 0);
   endtask

   task automatic load_use_stall();
      word_t a;
      word_t b;
      word_t c;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      load_dmem(0, a);
      load_dmem(1, b);
      load_dmem(2, c);
      emit(i_word(OP_LW, 1, 0, 16'h0), 0);
      emit(r_word(F_ADD, 2, 1, 1), 0);
      emit(i_word(OP_LW, 3, 0, 16'h4), 0);
      emit(r_word(F_SUB, 4, 2, 3), 0);
      // a lost or doubled increment shows up in r5
      emit(i_word(OP_ADDI, 5, 0, 16'd1), 0);
      emit(i_word(OP_ADDI, 5, 5, 16'd1), 0);
      emit(i_word(OP_ADDI, 5, 5, 16'd1), 0);
      emit(i_word(OP_LW, 6, 0, 16'h8), 0);
      emit(r_word(F_ADD, 7, 6, 5), 3);
      store_result(2, a + a);
      store_result(4, a + a - b);
      store_result(5, 32'd3);
      store_result(7, c + 32'd3);
      execute("load-use", 0, 0);
   endtask

   task automatic freeze_and_r0();
      word_t c;
      c = $random(seed);
      load_dmem(0, c);
      emit(i_word(OP_ADDI, 0, 0, 16'd77), 0);
      emit(i_word(OP_ADDI, 1, 0, 16'd5), 0);
      emit(i_word(OP_LW, 2, 0, 16'h0), 0);
      emit(r_word(F_ADD, 3, 2, 1), 0);
      emit(r_word(F_ADD, 4, 3, 0), 3);
      store_result(0, 32'd0);
      store_result(1, 32'd5);
      store_result(3, c + 32'd5);
      store_result(4, c + 32'd5);
      // freeze lands on the load-use stall
      execute("freeze", 4, 7);
   endtask

   initial begin
      seed        = 32'heb2a_05f2;
      errors      = 0;
      checks      = 0;
      clk         = 1'b0;
      rst_n       = 1'b0;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      reset_core();
      ext_port_readback();
      alu_ops();
      forwarding_paths();
      load_use_stall();
      freeze_and_r0();
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: include/cpu_macros.svh
/*
 * core-wide width macros
 * machine word, memory word-address and register address widths
 */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// machine word
`define CPU_DATA_W 32

// 512-word instruction memory, 1024-word data memory
`define CPU_IMEM_AW 9
`define CPU_DMEM_AW 10

// 32 general purpose registers
`define CPU_REG_AW 5

`endif

// File: project.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/sram.sv
source/decode_unit.sv
source/register_file.sv
source/hazard_unit.sv
source/alu.sv
source/cpu.sv
bench/cpu_tb.sv

// File: source/alu.sv
/*
 * integer ALU
 * add, sub, and, or and signed set-less-than
 */
module alu
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  word_t   a,
   input  word_t   b,
   input  alu_op_e op,
   output word_t   result
);

   always_comb begin
      case (op)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         // signed compare, result is 0 or 1
         ALU_SLT: result = word_t'($signed(a) < $signed(b));
         default: result = '0;
      endcase
   end

endmodule

// File: source/cpu.sv
/*
 * five-stage pipelined core, top level
 * PC, stage registers, forwarding and operand muxes, writeback mux
 * instruction and data memories with external load ports
 */
`include "cpu_macros.svh"

module cpu
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic [`CPU_IMEM_AW-1:0] addr_ext,
   input  logic                   wen_ext,
   input  logic                   ren_ext,
   input  word_t                  wdata_ext,
   output word_t                  rdata_ext,
   input  logic [`CPU_DMEM_AW-1:0] addr_ext_2,
   input  logic                   wen_ext_2,
   input  logic                   ren_ext_2,
   input  word_t                  wdata_ext_2,
   output word_t                  rdata_ext_2
);

   logic      stall, advance, bubble;
   word_t     pc_q;
   logic      ifid_valid;
   instr_t    ifid_instr;
   alu_op_e   dec_alu_op;
   logic      dec_alu_src, dec_reg_dst, dec_mem_read, dec_mem_write;
   logic      dec_mem_to_reg, dec_reg_write;
   word_t     rf_rdata_1, rf_rdata_2, imm_ext;
   word_t     idex_rs_data, idex_rt_data, idex_imm;
   reg_addr_t idex_rs, idex_rt, idex_rd;
   alu_op_e   idex_alu_op;
   logic      idex_alu_src, idex_mem_read, idex_mem_write, idex_mem_to_reg, idex_reg_write;
   fwd_sel_e  fwd_a, fwd_b;
   word_t     op_a, rt_fwd, op_b, alu_result;
   word_t     exmem_alu, exmem_store;
   reg_addr_t exmem_rd;
   logic      exmem_mem_read, exmem_mem_write, exmem_mem_to_reg, exmem_reg_write;
   word_t     memwb_alu, dmem_rdata, wb_data;
   reg_addr_t memwb_rd;
   logic      memwb_mem_to_reg, memwb_reg_write;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t ex_val,
                                     word_t wb_val);
      case (sel)
         FWD_EXMEM: return ex_val;
         FWD_MEMWB: return wb_val;
         default:   return rf_val;
      endcase
   endfunction

   assign advance = enable && !stall;

   // IF: PC and IF/ID, the fetched word itself is the registered sram output
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q       <= '0;
         ifid_valid <= 1'b0;
      end else if (advance) begin
         pc_q       <= pc_q + word_t'(4);
         ifid_valid <= 1'b1;
      end
   end

   sram #(.AW(`CPU_IMEM_AW), .payload_t(instr_t)) instr_mem (
      .clk       (clk),
      .addr      (pc_q[`CPU_IMEM_AW+1:2]),
      .wen       (1'b0),
      .ren       (advance),
      .wdata     ('0),
      .rdata     (ifid_instr),
      .addr_ext  (addr_ext),
      .wen_ext   (wen_ext),
      .ren_ext   (ren_ext),
      .wdata_ext (wdata_ext),
      .rdata_ext (rdata_ext)
   );

   // ID
   decode_unit decode (
      .instr      (ifid_instr),
      .alu_op     (dec_alu_op),
      .alu_src    (dec_alu_src),
      .reg_dst    (dec_reg_dst),
      .mem_read   (dec_mem_read),
      .mem_write  (dec_mem_write),
      .mem_to_reg (dec_mem_to_reg),
      .reg_write  (dec_reg_write)
   );

   register_file regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_write (memwb_reg_write && enable),
      .waddr     (memwb_rd),
      .wdata     (wb_data),
      .raddr_1   (ifid_instr.r.rs),
      .raddr_2   (ifid_instr.r.rt),
      .rdata_1   (rf_rdata_1),
      .rdata_2   (rf_rdata_2)
   );

   hazard_unit hazard (
      .idex_mem_read   (idex_mem_read),
      .idex_rt         (idex_rt),
      .ifid_rs         (ifid_instr.r.rs),
      .ifid_rt         (ifid_instr.r.rt),
      .idex_rs         (idex_rs),
      .exmem_reg_write (exmem_reg_write),
      .exmem_rd        (exmem_rd),
      .memwb_reg_write (memwb_reg_write),
      .memwb_rd        (memwb_rd),
      .stall           (stall),
      .fwd_a           (fwd_a),
      .fwd_b           (fwd_b)
   );

   assign imm_ext = {{(`CPU_DATA_W-16){ifid_instr.i.imm[15]}}, ifid_instr.i.imm};
   // nothing valid fetched yet, or load-use hazard
   assign bubble  = stall || !ifid_valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idex_alu_op     <= ALU_ADD;
         idex_alu_src    <= 1'b0;
         idex_mem_read   <= 1'b0;
         idex_mem_write  <= 1'b0;
         idex_mem_to_reg <= 1'b0;
         idex_reg_write  <= 1'b0;
      end else if (enable) begin
         idex_alu_op     <= bubble ? ALU_ADD : dec_alu_op;
         idex_alu_src    <= dec_alu_src && !bubble;
         idex_mem_read   <= dec_mem_read && !bubble;
         idex_mem_write  <= dec_mem_write && !bubble;
         idex_mem_to_reg <= dec_mem_to_reg && !bubble;
         idex_reg_write  <= dec_reg_write && !bubble;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         idex_rs_data <= rf_rdata_1;
         idex_rt_data <= rf_rdata_2;
         idex_imm     <= imm_ext;
         idex_rs      <= ifid_instr.r.rs;
         idex_rt      <= ifid_instr.r.rt;
         idex_rd      <= dec_reg_dst ? ifid_instr.r.rd : ifid_instr.r.rt;
      end
   end

   // EX
   assign op_a   = fwd_mux(fwd_a, idex_rs_data, exmem_alu, wb_data);
   assign rt_fwd = fwd_mux(fwd_b, idex_rt_data, exmem_alu, wb_data);
   assign op_b   = idex_alu_src ? idex_imm : rt_fwd;

   alu ex_alu (
      .a      (op_a),
      .b      (op_b),
      .op     (idex_alu_op),
      .result (alu_result)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exmem_mem_read   <= 1'b0;
         exmem_mem_write  <= 1'b0;
         exmem_mem_to_reg <= 1'b0;
         exmem_reg_write  <= 1'b0;
         memwb_mem_to_reg <= 1'b0;
         memwb_reg_write  <= 1'b0;
      end else if (enable) begin
         exmem_mem_read   <= idex_mem_read;
         exmem_mem_write  <= idex_mem_write;
         exmem_mem_to_reg <= idex_mem_to_reg;
         exmem_reg_write  <= idex_reg_write;
         memwb_mem_to_reg <= exmem_mem_to_reg;
         memwb_reg_write  <= exmem_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         exmem_alu   <= alu_result;
         exmem_store <= rt_fwd;
         exmem_rd    <= idex_rd;
         memwb_alu   <= exmem_alu;
         memwb_rd    <= exmem_rd;
      end
   end

   // MEM, byte address from the ALU, word-addressed memory
   sram #(.AW(`CPU_DMEM_AW), .payload_t(word_t)) data_mem (
      .clk       (clk),
      .addr      (exmem_alu[`CPU_DMEM_AW+1:2]),
      .wen       (exmem_mem_write && enable),
      .ren       (exmem_mem_read && enable),
      .wdata     (exmem_store),
      .rdata     (dmem_rdata),
      .addr_ext  (addr_ext_2),
      .wen_ext   (wen_ext_2),
      .ren_ext   (ren_ext_2),
      .wdata_ext (wdata_ext_2),
      .rdata_ext (rdata_ext_2)
   );

   // WB
   assign wb_data = memwb_mem_to_reg ? dmem_rdata : memwb_alu;

endmodule

// File: source/decode_unit.sv
/*
 * main and ALU control decode
 * opcode to datapath controls, funct to ALU operation for register forms
 */
module decode_unit
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  instr_t  instr,
   output alu_op_e alu_op,
   output logic    alu_src,
   output logic    reg_dst,
   output logic    mem_read,
   output logic    mem_write,
   output logic    mem_to_reg,
   output logic    reg_write
);

   always_comb begin
      alu_op     = ALU_ADD;
      alu_src    = 1'b0;
      reg_dst    = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      reg_write  = 1'b0;
      case (instr.r.opcode)
         OP_RTYPE: begin
            reg_dst   = 1'b1;
            reg_write = 1'b1;
            case (instr.r.funct)
               F_ADD:   alu_op = ALU_ADD;
               F_SUB:   alu_op = ALU_SUB;
               F_AND:   alu_op = ALU_AND;
               F_OR:    alu_op = ALU_OR;
               F_SLT:   alu_op = ALU_SLT;
               // unsupported funct, incl. the all-zero nop
               default: begin
                  reg_dst   = 1'b0;
                  reg_write = 1'b0;
               end
            endcase
         end
         OP_ADDI: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         OP_LW: begin
            alu_src    = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
            reg_write  = 1'b1;
         end
         OP_SW: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: source/hazard_unit.sv
/*
 * hazard unit
 * EX operand forwarding select and load-use stall detection
 */
module hazard_unit
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic      idex_mem_read,
   input  reg_addr_t idex_rt,
   input  reg_addr_t ifid_rs,
   input  reg_addr_t ifid_rt,
   input  reg_addr_t idex_rs,
   input  logic      exmem_reg_write,
   input  reg_addr_t exmem_rd,
   input  logic      memwb_reg_write,
   input  reg_addr_t memwb_rd,
   output logic      stall,
   output fwd_sel_e  fwd_a,
   output fwd_sel_e  fwd_b
);

   // nearest producer wins
   function automatic fwd_sel_e fwd_select(reg_addr_t src);
      fwd_sel_e sel;
      sel = FWD_NONE;
      if (exmem_reg_write && exmem_rd != '0 && exmem_rd == src) begin
         sel = FWD_EXMEM;
      end else if (memwb_reg_write && memwb_rd != '0 && memwb_rd == src) begin
         sel = FWD_MEMWB;
      end
      return sel;
   endfunction

   assign fwd_a = fwd_select(idex_rs);
   assign fwd_b = fwd_select(idex_rt);

   // load in EX feeding the instruction in ID
   assign stall = idex_mem_read && (idex_rt == ifid_rs || idex_rt == ifid_rt);

   always_comb begin
      assert final (!(fwd_a == FWD_EXMEM && idex_rs == '0))
         else $error("register 0 forwarded from EX/MEM");
   end

endmodule

// File: source/isa_pkg.sv
/*
 * instruction set encoding
 * word and register types, instruction field views, opcode and funct codes
 */
`include "cpu_macros.svh"

package isa_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;
   typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fmt_t;

   // immediate form shares opcode, rs and rt with the register form
   typedef struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B
   } opcode_e;

   typedef enum logic [5:0] {
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_SLT = 6'h2A
   } funct_e;

endpackage

// File: source/pipe_pkg.sv
/*
 * pipeline internal controls
 * ALU operation select and operand forwarding source
 */
package pipe_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   // where an EX operand is taken from
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_EXMEM,
      FWD_MEMWB
   } fwd_sel_e;

endpackage

// File: source/register_file.sv
/*
 * 32-entry register file
 * two combinational read ports with write-through, register 0 reads zero
 */
module register_file
   import isa_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      reg_write,
   input  reg_addr_t waddr,
   input  word_t     wdata,
   input  reg_addr_t raddr_1,
   input  reg_addr_t raddr_2,
   output word_t     rdata_1,
   output word_t     rdata_2
);

   word_t regs [2**$bits(reg_addr_t)];
   logic  wr_live;

   assign wr_live = reg_write && (waddr != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[waddr] <= wdata;
      end
   end

   // WB value seen by the ID read in the same cycle
   assign rdata_1 = (wr_live && waddr == raddr_1) ? wdata : regs[raddr_1];
   assign rdata_2 = (wr_live && waddr == raddr_2) ? wdata : regs[raddr_2];

   assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
      else $error("register 0 holds a nonzero value");

endmodule

// File: source/sram.sv
/*
 * synchronous memory with a core port and an external port
 * registered reads on both ports, external write has priority
 */
module sram
   import isa_pkg::*;
#(
   parameter int  AW        = 10,
   parameter type payload_t = word_t
) (
   input  logic          clk,
   input  logic [AW-1:0] addr,
   input  logic          wen,
   input  logic          ren,
   input  payload_t      wdata,
   output payload_t      rdata,
   input  logic [AW-1:0] addr_ext,
   input  logic          wen_ext,
   input  logic          ren_ext,
   input  payload_t      wdata_ext,
   output payload_t      rdata_ext
);

   payload_t mem [2**AW];

   always_ff @(posedge clk) begin
      if (wen_ext) begin
         mem[addr_ext] <= wdata_ext;
      end else if (wen) begin
         mem[addr] <= wdata;
      end
   end

   // read data holds until the next read strobe
   always_ff @(posedge clk) begin
      if (ren) begin
         rdata <= mem[addr];
      end
      if (ren_ext) begin
         rdata_ext <= mem[addr_ext];
      end
   end

   // external loading is only legal while the core is frozen
   assert property (@(posedge clk) !(wen_ext && wen))
      else $error("external write collides with a core write");

endmodule
